//--- Makefile
# Verilator build and run of the arcade core testbench

TOP = tb_arcade_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir -o $(TOP)

# a run that aborts early prints neither message and also fails
run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/arcade_core_top.sv
// arcade core top level
// ties the config registers, control mapping, raster timing
// and video formatting to the game core ports

`timescale 1ns/1ps

module arcade_core_top (
    input  logic                       clk_74a,
    input  logic                       pll_core_locked,
    input  logic                       bridge_wr,
    input  logic                       pix_ce,
    input  logic [31:0]                bridge_addr,
    input  logic [31:0]                bridge_wr_data,
    input  core_cfg_pkg::key_map_t     cont1_key,
    input  core_cfg_pkg::key_map_t     cont2_key,
    input  video_pkg::pixel_index_t    pixel_index,
    output core_cfg_pkg::board_type_e  board_model,
    output logic [31:0]                game_settings,
    output core_cfg_pkg::player_ctrl_t player1,
    output core_cfg_pkg::player_ctrl_t player2,
    output core_cfg_pkg::system_ctrl_t system_ctrl,
    output video_pkg::raster_pos_t     hpos,
    output video_pkg::raster_pos_t     vpos,
    output video_pkg::video_out_t      video
);

    video_pkg::raster_t raster;

    // game core needs the raw position
    assign hpos = raster.hpos;
    assign vpos = raster.vpos;

    game_config_regs i_config (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .bridge_wr       (bridge_wr),
        .bridge_addr     (bridge_addr),
        .bridge_wr_data  (bridge_wr_data),
        .board_model     (board_model),
        .game_settings   (game_settings)
    );

    control_mapper i_control (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .cont1_key       (cont1_key),
        .cont2_key       (cont2_key),
        .player1         (player1),
        .player2         (player2),
        .system_ctrl     (system_ctrl)
    );

    raster_timing i_raster (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .pix_ce          (pix_ce),
        .raster          (raster)
    );

    video_output i_video (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .pix_ce          (pix_ce),
        .raster          (raster),
        .pixel_index     (pixel_index),
        .video           (video)
    );

endmodule

//--- rtl/control_mapper.sv
// controller input mapping
// synchronizes both key words, slices them into player buttons
// and stretches a coin release into a fixed length pulse

`timescale 1ns/1ps

module control_mapper (
    input  logic                       clk_74a,
    input  logic                       pll_core_locked,
    input  core_cfg_pkg::key_map_t     cont1_key,
    input  core_cfg_pkg::key_map_t     cont2_key,
    output core_cfg_pkg::player_ctrl_t player1,
    output core_cfg_pkg::player_ctrl_t player2,
    output core_cfg_pkg::system_ctrl_t system_ctrl
);

    // both controllers share one shift chain, cont2 in the upper half
    logic [core_cfg_pkg::sync_stages-1:0][31:0] key_sync;
    core_cfg_pkg::key_map_t key1;
    core_cfg_pkg::key_map_t key2;
    logic                   coin_level;
    logic                   coin_prev;
    logic [7:0]             coin_cnt;

    ////////////////////
    // synchronizer
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            key_sync <= '0;
        end else begin
            key_sync <= {key_sync[core_cfg_pkg::sync_stages-2:0], cont2_key, cont1_key};
        end
    end

    assign key1 = core_cfg_pkg::key_map_t'(key_sync[core_cfg_pkg::sync_stages-1][15:0]);
    assign key2 = core_cfg_pkg::key_map_t'(key_sync[core_cfg_pkg::sync_stages-1][31:16]);

    ////////////////////
    // button slicing
    assign player1 = '{fire_b: key1.face_b, fire: key1.face_a, left: key1.dpad_left,
                       down: key1.dpad_down, right: key1.dpad_right, up: key1.dpad_up};
    assign player2 = '{fire_b: key2.face_b, fire: key2.face_a, left: key2.dpad_left,
                       down: key2.dpad_down, right: key2.dpad_right, up: key2.dpad_up};

    // select on either pad drops a coin
    assign coin_level = key1.face_select | key2.face_select;

    ////////////////////
    // coin pulse stretcher
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            coin_prev <= 1'b0;
            coin_cnt  <= 8'd0;
        end else begin
            coin_prev <= coin_level;
            if (coin_cnt != 8'd0) begin
                coin_cnt <= coin_cnt - 8'd1;
            end else if (coin_prev && !coin_level) begin
                // fires on release, not on press
                coin_cnt <= core_cfg_pkg::coin_pulse_cycles;
            end
        end
    end

    assign system_ctrl = '{coin: (coin_cnt != 8'd0), start2: key2.face_start,
                           start1: key1.face_start};

endmodule

//--- rtl/core_cfg_pkg.sv
// configuration and control definitions
// bridge register map, game and board ids, controller layouts

package core_cfg_pkg;

    ////////////////////
    // bridge register map
    localparam logic [31:0] addr_game_id       = 32'h80000000;
    localparam logic [31:0] addr_game_settings = 32'h90000000;

    typedef enum logic [2:0] {
        game_druaga   = 3'd1,
        game_mappy    = 3'd2,
        game_digdug2  = 3'd3,
        game_motos    = 3'd4,
        game_superpac = 3'd5,
        game_grobda   = 3'd6
    } game_id_e;

    typedef enum logic [2:0] {
        board_druaga   = 3'd0,
        board_superpac = 3'd5,
        board_grobda   = 3'd6
    } board_type_e;

    ////////////////////
    // controller side
    typedef struct packed {
        logic       face_start;
        logic       face_select;
        logic [4:0] spare_hi;
        logic       trig_l1;
        logic [1:0] spare_lo;
        logic       face_b;
        logic       face_a;
        logic       dpad_right;
        logic       dpad_left;
        logic       dpad_down;
        logic       dpad_up;
    } key_map_t;

    // bit order matches the game core inputs {b2, b1, l, d, r, u}
    typedef struct packed {
        logic fire_b;
        logic fire;
        logic left;
        logic down;
        logic right;
        logic up;
    } player_ctrl_t;

    typedef struct packed {
        logic coin;
        logic start2;
        logic start1;
    } system_ctrl_t;

    localparam logic [7:0] coin_pulse_cycles = 8'd255;
    localparam int         sync_stages       = 3;

endpackage

//--- rtl/game_config_regs.sv
// game configuration registers
// catches bridge writes for game id and settings, derives board model

`timescale 1ns/1ps

module game_config_regs (
    input  logic                      clk_74a,
    input  logic                      pll_core_locked,
    input  logic                      bridge_wr,
    input  logic [31:0]               bridge_addr,
    input  logic [31:0]               bridge_wr_data,
    output core_cfg_pkg::board_type_e board_model,
    output logic [31:0]               game_settings
);

    logic [2:0] game_id;

    ////////////////////
    // bridge write decode
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            game_id       <= 3'd0;
            game_settings <= 32'd0;
        end else if (bridge_wr) begin
            if (bridge_addr == core_cfg_pkg::addr_game_id) begin
                game_id <= bridge_wr_data[2:0];
            end
            if (bridge_addr == core_cfg_pkg::addr_game_settings) begin
                game_settings <= bridge_wr_data;
            end
        end
    end

    ////////////////////
    // board model, one edge behind the id
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            board_model <= core_cfg_pkg::board_druaga;
        end else begin
            case (game_id)
                core_cfg_pkg::game_grobda:   board_model <= core_cfg_pkg::board_grobda;
                core_cfg_pkg::game_superpac: board_model <= core_cfg_pkg::board_superpac;
                // mappy, digdug2, motos and unknown ids share the druaga board
                default:                     board_model <= core_cfg_pkg::board_druaga;
            endcase
        end
    end

endmodule

//--- rtl/raster_timing.sv
// raster timing generator
// horizontal and vertical counters with the original jump points,
// plus blanking and active low sync levels, stepped by pix_ce

`timescale 1ns/1ps

module raster_timing (
    input  logic               clk_74a,
    input  logic               pll_core_locked,
    input  logic               pix_ce,
    output video_pkg::raster_t raster
);

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            raster.hpos    <= '0;
            raster.vpos    <= '0;
            raster.hblank  <= 1'b1;
            raster.vblank  <= 1'b1;
            raster.hsync_n <= 1'b1;
            raster.vsync_n <= 1'b1;
        end else if (pix_ce) begin
            case (raster.hpos)
                video_pkg::h_active_start: begin
                    raster.hblank <= 1'b0;
                    raster.hpos   <= raster.hpos + 9'd1;
                end
                video_pkg::h_active_end: begin
                    raster.hblank <= 1'b1;
                    raster.hpos   <= raster.hpos + 9'd1;
                end
                video_pkg::h_sync_start: begin
                    raster.hsync_n <= 1'b0;
                    raster.hpos    <= raster.hpos + 9'd1;
                end
                video_pkg::h_sync_end: begin
                    // skip ahead, line is 384 ticks
                    raster.hsync_n <= 1'b1;
                    raster.hpos    <= video_pkg::h_resume;
                end
                video_pkg::count_max: begin
                    raster.hpos <= '0;
                    ////////////////////
                    // line step
                    case (raster.vpos)
                        video_pkg::v_active_end: begin
                            raster.vblank <= 1'b1;
                            raster.vpos   <= raster.vpos + 9'd1;
                        end
                        video_pkg::v_sync_start: begin
                            raster.vsync_n <= 1'b0;
                            raster.vpos    <= raster.vpos + 9'd1;
                        end
                        video_pkg::v_sync_end: begin
                            raster.vsync_n <= 1'b1;
                            raster.vpos    <= video_pkg::v_resume;
                        end
                        video_pkg::count_max: begin
                            raster.vblank <= 1'b0;
                            raster.vpos   <= '0;
                        end
                        default: raster.vpos <= raster.vpos + 9'd1;
                    endcase
                end
                default: raster.hpos <= raster.hpos + 9'd1;
            endcase
        end
    end

endmodule

//--- rtl/video_output.sv
// video output formatter
// expands the pixel index to rgb888, blanks outside the active area
// and turns the sync level edges into one tick pulses

`timescale 1ns/1ps

module video_output (
    input  logic                    clk_74a,
    input  logic                    pll_core_locked,
    input  logic                    pix_ce,
    input  video_pkg::raster_t      raster,
    input  video_pkg::pixel_index_t pixel_index,
    output video_pkg::video_out_t   video
);

    logic        active;
    logic [23:0] rgb_full;
    logic        hsync_prev;
    logic        vsync_prev;

    assign active = !(raster.hblank || raster.vblank);

    // each channel padded to 4 bits then repeated into a byte
    assign rgb_full = {{2{pixel_index.red, 1'b0}},
                       {2{pixel_index.green, 1'b0}},
                       {2{pixel_index.blue, 2'b00}}};

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            video      <= '0;
            hsync_prev <= 1'b1;
            vsync_prev <= 1'b1;
        end else if (pix_ce) begin
            video.de   <= active;
            video.rgb  <= active ? rgb_full : 24'd0;
            // pulse at the end of each sync period
            video.hs   <= raster.hsync_n && !hsync_prev;
            video.vs   <= raster.vsync_n && !vsync_prev;
            hsync_prev <= raster.hsync_n;
            vsync_prev <= raster.vsync_n;
        end
    end

endmodule

//--- rtl/video_pkg.sv
// video timing and pixel definitions
// raster counter breakpoints, pixel index layout, output bundle

package video_pkg;

    typedef logic [8:0] raster_pos_t;

    ////////////////////
    // horizontal breakpoints
    localparam raster_pos_t h_active_start = 9'd1;
    localparam raster_pos_t h_active_end   = 9'd290;
    localparam raster_pos_t h_sync_start   = 9'd311;
    localparam raster_pos_t h_sync_end     = 9'd342;
    localparam raster_pos_t h_resume       = 9'd471;

    ////////////////////
    // vertical breakpoints
    localparam raster_pos_t v_active_end   = 9'd223;
    localparam raster_pos_t v_sync_start   = 9'd234;
    localparam raster_pos_t v_sync_end     = 9'd241;
    localparam raster_pos_t v_resume       = 9'd491;

    // both counters wrap here
    localparam raster_pos_t count_max      = 9'd511;

    typedef struct packed {
        raster_pos_t hpos;
        raster_pos_t vpos;
        logic        hblank;
        logic        vblank;
        logic        hsync_n;
        logic        vsync_n;
    } raster_t;

    // palette index from the game core, bbgggrrr
    typedef struct packed {
        logic [1:0] blue;
        logic [2:0] green;
        logic [2:0] red;
    } pixel_index_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

endpackage

//--- sim.f
rtl/core_cfg_pkg.sv
rtl/video_pkg.sv
rtl/game_config_regs.sv
rtl/control_mapper.sv
rtl/raster_timing.sv
rtl/video_output.sv
rtl/arcade_core_top.sv
sim/clock_gen.sv
sim/arcade_core_properties.sv
sim/tb_arcade_core.sv

//--- sim/arcade_core_properties.sv
// concurrent checks on the arcade core top level
// rgb blanking, legal board model, single tick sync pulses

`timescale 1ns/1ps

module arcade_core_properties (
    input logic                  clk_74a,
    input logic                  pll_core_locked,
    input logic                  pix_ce,
    input logic [2:0]            board_model,
    input video_pkg::video_out_t video
);

    // sync pulses from the previous pix_ce tick
    logic hs_last;
    logic vs_last;

    // number of assertion failures so far
    int   failures = 0;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            hs_last <= 1'b0;
            vs_last <= 1'b0;
        end else if (pix_ce) begin
            hs_last <= video.hs;
            vs_last <= video.vs;
        end
    end

    rgb_blanked: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        !video.de |-> video.rgb == 24'd0)
        else begin
            failures++;
            $error("rgb not zero while de is low");
        end

    board_legal: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        board_model inside {core_cfg_pkg::board_druaga, core_cfg_pkg::board_superpac,
                            core_cfg_pkg::board_grobda})
        else begin
            failures++;
            $error("board_model holds an illegal value");
        end

    hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        pix_ce && hs_last |-> !video.hs)
        else begin
            failures++;
            $error("hs high on two consecutive ticks");
        end

    vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        pix_ce && vs_last |-> !video.vs)
        else begin
            failures++;
            $error("vs high on two consecutive ticks");
        end

endmodule

//--- sim/clock_gen.sv
// testbench clock and reset source
// 8 ns clock, active low reset held for 10 cycles

`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // release on a falling edge, away from the DUT sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- sim/tb_arcade_core.sv
// arcade core testbench
// config writes, button mapping, coin pulse, frame structure and pixel colors

`timescale 1ns/1ps

module tb_arcade_core;

    logic                       clk_74a;
    logic                       pll_core_locked;
    logic                       bridge_wr;
    logic                       pix_ce;
    logic [31:0]                bridge_addr;
    logic [31:0]                bridge_wr_data;
    core_cfg_pkg::key_map_t     cont1_key;
    core_cfg_pkg::key_map_t     cont2_key;
    video_pkg::pixel_index_t    pixel_index;
    core_cfg_pkg::board_type_e  board_model;
    logic [31:0]                game_settings;
    core_cfg_pkg::player_ctrl_t player1;
    core_cfg_pkg::player_ctrl_t player2;
    core_cfg_pkg::system_ctrl_t system_ctrl;
    video_pkg::raster_pos_t     hpos;
    video_pkg::raster_pos_t     vpos;
    video_pkg::video_out_t      video;

    // ring of posted comparisons drained by the comparing process
    string       check_name [128];
    logic [31:0] check_act [128];
    logic [31:0] check_exp [128];
    int          wr_ptr;
    int          rd_ptr = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts;

    // frame monitor states are 0 idle, 1 seeking vs, 2 counting, 3 done
    logic                    frame_request;
    int                      frame_state = 0;
    int                      de_ticks = 0;
    int                      hs_pulses = 0;
    int                      vs_pulses = 0;
    logic                    ce_seen = 1'b0;
    video_pkg::pixel_index_t idx_seen;

    clock_gen i_clk (
        .clk   (clk_74a),
        .rst_n (pll_core_locked)
    );

    arcade_core_top i_dut (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .bridge_wr       (bridge_wr),
        .pix_ce          (pix_ce),
        .bridge_addr     (bridge_addr),
        .bridge_wr_data  (bridge_wr_data),
        .cont1_key       (cont1_key),
        .cont2_key       (cont2_key),
        .pixel_index     (pixel_index),
        .board_model     (board_model),
        .game_settings   (game_settings),
        .player1         (player1),
        .player2         (player2),
        .system_ctrl     (system_ctrl),
        .hpos            (hpos),
        .vpos            (vpos),
        .video           (video)
    );

    bind arcade_core_top arcade_core_properties i_props (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .pix_ce          (pix_ce),
        .board_model     (board_model),
        .video           (video)
    );

    ////////////////////
    // reference models
    function automatic core_cfg_pkg::board_type_e board_for_id(input logic [2:0] id);
        if (id == core_cfg_pkg::game_grobda) begin
            return core_cfg_pkg::board_grobda;
        end else if (id == core_cfg_pkg::game_superpac) begin
            return core_cfg_pkg::board_superpac;
        end
        return core_cfg_pkg::board_druaga;
    endfunction

    function automatic logic [23:0] expand_rgb(input video_pkg::pixel_index_t p);
        logic [3:0] r4;
        logic [3:0] g4;
        logic [3:0] b4;
        r4 = {p.red, 1'b0};
        g4 = {p.green, 1'b0};
        b4 = {p.blue, 2'b00};
        return {r4, r4, g4, g4, b4, b4};
    endfunction

    function automatic core_cfg_pkg::player_ctrl_t player_from_keys(
        input core_cfg_pkg::key_map_t k
    );
        core_cfg_pkg::player_ctrl_t p;
        p.up     = k.dpad_up;
        p.right  = k.dpad_right;
        p.down   = k.dpad_down;
        p.left   = k.dpad_left;
        p.fire   = k.face_a;
        p.fire_b = k.face_b;
        return p;
    endfunction

    function automatic int active_ticks_per_frame();
        return (int'(video_pkg::v_active_end) + 1) *
               (int'(video_pkg::h_active_end) - int'(video_pkg::h_active_start));
    endfunction

    // lines up to the vertical jump plus the lines from resume to wrap
    function automatic int lines_per_frame();
        return int'(video_pkg::v_sync_end) + 1 +
               int'(video_pkg::count_max) - int'(video_pkg::v_resume) + 1;
    endfunction

    ////////////////////
    // helpers
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic post_check(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        check_name[wr_ptr % 128] = name;
        check_act[wr_ptr % 128]  = actual;
        check_exp[wr_ptr % 128]  = expected;
        wr_ptr++;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_74a);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
        @(negedge clk_74a);
    endtask

    task automatic set_coin(input int player, input logic level);
        if (player == 1) begin
            cont1_key.face_select = level;
        end else begin
            cont2_key.face_select = level;
        end
    endtask

    task automatic coin_pulse_test(input int player);
        int   n;
        int   high;
        logic seen;
        @(negedge clk_74a);
        set_coin(player, 1'b1);
        repeat (6) @(negedge clk_74a);
        set_coin(player, 1'b0);
        for (n = 0; n < 20 && !system_ctrl.coin; n++) begin
            @(negedge clk_74a);
        end
        if (!system_ctrl.coin) begin
            report_timeout("coin pulse start");
        end
        high = 0;
        for (n = 0; n < 400 && system_ctrl.coin; n++) begin
            high++;
            // press and release again inside the pulse
            if (high == 40) begin
                set_coin(player, 1'b1);
            end
            if (high == 60) begin
                set_coin(player, 1'b0);
            end
            @(negedge clk_74a);
        end
        if (system_ctrl.coin) begin
            report_timeout("coin pulse end");
        end
        post_check("coin pulse length", 32'(high), 32'(core_cfg_pkg::coin_pulse_cycles));
        seen = 1'b0;
        for (n = 0; n < 20; n++) begin
            @(negedge clk_74a);
            seen = seen | system_ctrl.coin;
        end
        post_check("coin retrigger", 32'(seen), 32'd0);
    endtask

    ////////////////////
    // comparing process
    always @(posedge clk_74a) begin
        ce_seen  <= pix_ce;
        idx_seen <= pixel_index;
    end

    always @(negedge clk_74a) begin
        while (rd_ptr != wr_ptr) begin
            check_value(check_name[rd_ptr % 128], check_act[rd_ptr % 128],
                        check_exp[rd_ptr % 128]);
            rd_ptr++;
        end
        if (frame_state == 0 && frame_request) begin
            frame_state = 1;
        end
        if (pll_core_locked && ce_seen) begin
            // rgb is one tick behind the index
            if (video.de) begin
                check_value("video.rgb", 32'(video.rgb), 32'(expand_rgb(idx_seen)));
            end
            if (video.vs) begin
                // vs trails the line wrap into v_resume by one tick
                check_value("hpos", 32'(hpos), 32'd1);
                check_value("vpos", 32'(vpos), 32'(video_pkg::v_resume));
            end
            if (frame_state == 1 && video.vs) begin
                frame_state = 2;
                de_ticks    = 0;
                hs_pulses   = 0;
                vs_pulses   = 0;
            end else if (frame_state == 2) begin
                de_ticks  = de_ticks + int'(video.de);
                hs_pulses = hs_pulses + int'(video.hs);
                if (video.vs) begin
                    vs_pulses++;
                    frame_state = 3;
                end
            end
        end
    end

    ////////////////////
    // stimulus
    initial begin
        int                     n;
        int                     assert_fails;
        logic [31:0]            r;
        logic [31:0]            data;
        logic [31:0]            addr;
        logic [31:0]            exp_settings;
        logic [2:0]             exp_id;
        core_cfg_pkg::key_map_t k1;
        core_cfg_pkg::key_map_t k2;

        bridge_wr      = 1'b0;
        bridge_addr    = 32'd0;
        bridge_wr_data = 32'd0;
        pix_ce         = 1'b0;
        cont1_key      = '0;
        cont2_key      = '0;
        pixel_index    = '0;
        wr_ptr         = 0;
        timeouts       = 0;
        frame_request  = 1'b0;
        exp_id         = 3'd0;
        exp_settings   = 32'd0;
        void'($urandom(32'h5c46));

        for (n = 0; n < 100 && !pll_core_locked; n++) begin
            @(negedge clk_74a);
        end
        if (!pll_core_locked) begin
            report_timeout("reset release");
        end
        @(negedge clk_74a);
        post_check("board_model", 32'(board_model), 32'(core_cfg_pkg::board_druaga));
        post_check("game_settings", game_settings, 32'd0);
        post_check("video", 32'(video), 32'd0);
        post_check("hpos", 32'(hpos), 32'd0);
        post_check("vpos", 32'(vpos), 32'd0);

        // config writes with some to unrelated addresses
        for (n = 0; n < 16; n++) begin
            r = $urandom();
            case (r % 32'd3)
                32'd0: begin
                    data = 32'd1 + ($urandom() % 32'd7);
                    bridge_write(core_cfg_pkg::addr_game_id, data);
                    exp_id = data[2:0];
                end
                32'd1: begin
                    data = $urandom();
                    bridge_write(core_cfg_pkg::addr_game_settings, data);
                    exp_settings = data;
                end
                default: begin
                    addr = $urandom();
                    if (addr == core_cfg_pkg::addr_game_id ||
                        addr == core_cfg_pkg::addr_game_settings) begin
                        addr = addr ^ 32'h1;
                    end
                    bridge_write(addr, $urandom());
                end
            endcase
            post_check("board_model", 32'(board_model), 32'(board_for_id(exp_id)));
            post_check("game_settings", game_settings, exp_settings);
        end

        // button mapping with coin bits held low
        for (n = 0; n < 8; n++) begin
            @(negedge clk_74a);
            r  = $urandom();
            k1 = core_cfg_pkg::key_map_t'(r[15:0]);
            k2 = core_cfg_pkg::key_map_t'(r[31:16]);
            k1.face_select = 1'b0;
            k2.face_select = 1'b0;
            cont1_key = k1;
            cont2_key = k2;
            repeat (core_cfg_pkg::sync_stages) @(negedge clk_74a);
            post_check("player1", 32'(player1), 32'(player_from_keys(k1)));
            post_check("player2", 32'(player2), 32'(player_from_keys(k2)));
            post_check("start1", 32'(system_ctrl.start1), 32'(k1.face_start));
            post_check("start2", 32'(system_ctrl.start2), 32'(k2.face_start));
        end
        @(negedge clk_74a);
        cont1_key = '0;
        cont2_key = '0;
        repeat (core_cfg_pkg::sync_stages + 2) @(negedge clk_74a);

        coin_pulse_test(1);
        coin_pulse_test(2);

        // one full frame between vs pulses with random pixels every tick
        frame_request = 1'b1;
        for (n = 0; n < 2 * lines_per_frame() * 512 && frame_state != 3; n++) begin
            @(negedge clk_74a);
            pix_ce      = 1'b1;
            pixel_index = video_pkg::pixel_index_t'(8'($urandom()));
            @(negedge clk_74a);
            pix_ce = 1'b0;
        end
        if (frame_state != 3) begin
            report_timeout("end of frame");
        end
        post_check("de ticks", 32'(de_ticks), 32'(active_ticks_per_frame()));
        post_check("hs pulses", 32'(hs_pulses), 32'(lines_per_frame()));
        post_check("vs pulses", 32'(vs_pulses), 32'd1);

        for (n = 0; n < 10 && rd_ptr != wr_ptr; n++) begin
            @(negedge clk_74a);
        end
        if (rd_ptr != wr_ptr) begin
            report_timeout("pending comparisons");
        end

        assert_fails = i_dut.i_props.failures;
        $display("checks=%0d errors=%0d assertion_failures=%0d timeouts=%0d",
                 checks, errors, assert_fails, timeouts);
        if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
